// File: project.f
+incdir+.
regfile_pkg.sv
regfile_ram_bank.sv
regfile_lvt.sv
regfile_fpga.sv
regfile_top.sv
regfile_tb.sv

// File: regfile_fpga.sv
// FPGA register file, one LUT-RAM bank per commit port, reads steered by the live value table
`timescale 1ns/1ps
`include "regfile_macros.svh"

module regfile_fpga #(
  // register zero reads as zero when set
  parameter bit ZERO_REG_ZERO = 1'b1
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // commit ports
  input  regfile_pkg::wr_port_t [`RF_NR_WRITE-1:0]    wr_i,
  // operand fetch ports
  input  logic [`RF_NR_READ-1:0][`RF_ADDR_W-1:0]      raddr_i,
  output logic [`RF_NR_READ-1:0][`RF_DATA_W-1:0]      rdata_o
);

  // highest-priority commit port
  localparam int unsigned TOP_PORT = `RF_NR_WRITE - 1;

  // every bank's word at every read address
  logic [`RF_NR_WRITE-1:0][`RF_NR_READ-1:0][`RF_DATA_W-1:0] bank_rdata;

  // bank holding the live value, per read port
  regfile_pkg::bank_sel_t [`RF_NR_READ-1:0] lvt_sel;

  // one bank per commit port
  // port j only ever writes bank j, so each bank keeps a single write port
  for (genvar j = 0; j < `RF_NR_WRITE; j++) begin : g_bank
    regfile_ram_bank u_bank (
      .clk_i   (clk_i),
      .wr_i    (wr_i[j]),
      .raddr_i (raddr_i),
      .rdata_o (bank_rdata[j])
    );
  end

  // live value table sees all ports to resolve same-cycle conflicts
  regfile_lvt u_lvt (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr_i    (wr_i),
    .raddr_i (raddr_i),
    .sel_o   (lvt_sel)
  );

  // output mux
  // pick the bank named by the table, then force zero for register 0 if enabled
  for (genvar k = 0; k < `RF_NR_READ; k++) begin : g_read
    assign rdata_o[k] = (ZERO_REG_ZERO && (raddr_i[k] == '0)) ? '0
                                                              : bank_rdata[lvt_sel[k]][k];
  end

  // operand addresses must be clean, an X here would pick an arbitrary bank
  a_raddr_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(raddr_i)
  ) else $error("read address carries unknown bits");

  // end to end check across table and banks
  // a write on the top port must be what the next cycle reads back
  // no lower port can override it, so this holds under any conflict
  for (genvar k = 0; k < `RF_NR_READ; k++) begin : g_wr_chk
    a_top_port_visible: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      ($past(rst_ni) && $past(wr_i[TOP_PORT].we) &&
       (raddr_i[k] == $past(wr_i[TOP_PORT].addr)) &&
       !(ZERO_REG_ZERO && (raddr_i[k] == '0)))
      |-> (rdata_o[k] == $past(wr_i[TOP_PORT].data))
    ) else $error("read port %0d missed the previous top port write", k);
  end

  // read path summary
  // address to data is combinational through bank and mux
  // the table select is already settled, it comes from flops
  // no bypass, a read in the write cycle returns the old word

  // area note
  // banks scale with write ports times read ports
  // the table is NUM_REGS times SEL_W flops

endmodule

// File: regfile_lvt.sv
// live value table, tracks which bank holds the latest value of every register
`timescale 1ns/1ps
`include "regfile_macros.svh"

module regfile_lvt (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // all commit ports, ordered by priority, highest index wins
  input  regfile_pkg::wr_port_t [`RF_NR_WRITE-1:0]    wr_i,
  // operand addresses
  input  logic [`RF_NR_READ-1:0][`RF_ADDR_W-1:0]      raddr_i,
  // bank index per read port, taken from the registered table
  output regfile_pkg::bank_sel_t [`RF_NR_READ-1:0]    sel_o
);

  // one-hot write enables, per port and per register
  logic [`RF_NR_WRITE-1:0][`RF_NUM_REGS-1:0] we_dec;

  // next and current bank index for every register
  regfile_pkg::bank_sel_t [`RF_NUM_REGS-1:0] sel_d;
  regfile_pkg::bank_sel_t [`RF_NUM_REGS-1:0] sel_q;

  // write address decode
  // a disabled port decodes to all zeros
  always_comb begin
    for (int unsigned j = 0; j < `RF_NR_WRITE; j++) begin
      for (int unsigned i = 0; i < `RF_NUM_REGS; i++) begin
        we_dec[j][i] = wr_i[j].we && (wr_i[j].addr == `RF_ADDR_W'(i));
      end
    end
  end

  // table update
  // ports are scanned in ascending order so the last match is the highest port
  // that gives the same-cycle priority the banks rely on
  always_comb begin
    sel_d = sel_q;
    for (int unsigned i = 0; i < `RF_NUM_REGS; i++) begin
      for (int unsigned j = 0; j < `RF_NR_WRITE; j++) begin
        if (we_dec[j][i]) begin
          sel_d[i] = regfile_pkg::bank_sel_t'(j);
        end
      end
    end
  end

  // table flops
  // after reset every register points to bank 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= '0;
    end else begin
      sel_q <= sel_d;
    end
  end

  // lookup at the read address
  // the registered table only, so a write is seen from the next cycle on
  for (genvar k = 0; k < `RF_NR_READ; k++) begin : g_lookup
    assign sel_o[k] = sel_q[raddr_i[k]];
  end

  // a select naming a bank that does not exist would read garbage
  for (genvar k = 0; k < `RF_NR_READ; k++) begin : g_sel_chk
    a_sel_in_range: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      int'(sel_o[k]) < `RF_NR_WRITE
    ) else $error("live value table select %0d out of range on port %0d", sel_o[k], k);
  end

endmodule

// File: regfile_macros.svh
// sizing macros for the register file, included by the package, the RTL and the testbench
`ifndef REGFILE_MACROS_SVH
`define REGFILE_MACROS_SVH

// number of architectural integer registers
`define RF_NUM_REGS 32

// register address width, enough to name every register
`define RF_ADDR_W 5

// width of one register
`define RF_DATA_W 32

// commit ports, one distributed-RAM bank each
`define RF_NR_WRITE 2

// operand fetch ports, all asynchronous
`define RF_NR_READ 2

// width of a bank index held in the live value table
// a single bank still gets one bit so the table never collapses to zero width
`define RF_SEL_W ((`RF_NR_WRITE == 1) ? 1 : $clog2(`RF_NR_WRITE))

`endif

// File: regfile_pkg.sv
// shared types of the register file, referenced by scoped name from the RTL and testbench
`include "regfile_macros.svh"

package regfile_pkg;

  // one commit port as seen by the register file
  // we is a plain strobe, sampled at the rising clock edge
  // addr names the destination register
  // data is the result being committed
  typedef struct packed {
    logic                  we;
    logic [`RF_ADDR_W-1:0] addr;
    logic [`RF_DATA_W-1:0] data;
  } wr_port_t;

  // index of the bank that holds a register's current value
  // bank j is written by commit port j only
  // value 0 is the state after reset
  typedef logic [`RF_SEL_W-1:0] bank_sel_t;

  // the read side needs no struct
  // a read port is just an address level and a data word
  // both are declared as packed arrays on the module ports

  // layout check for the write port word
  // enable in the top bit, then address, then data in the low bits
  // 1 + 5 + 32 = 38 bits with the default sizes

  // the bank index is compared against the number of write ports
  // in the live value table assertion
  // with two ports every encoding is legal
  // with three ports the code 3 would be a fault

  // no other shared definitions live here
  // sizes stay in the macro header

endpackage

// File: regfile_ram_bank.sv
// one distributed-RAM bank of the register file, written by a single commit port
`timescale 1ns/1ps
`include "regfile_macros.svh"

module regfile_ram_bank (
  // write clock, the bank has no reset
  input  logic                                       clk_i,
  // the one commit port that owns this bank
  input  regfile_pkg::wr_port_t                      wr_i,
  // operand addresses, one per read port
  input  logic [`RF_NR_READ-1:0][`RF_ADDR_W-1:0]     raddr_i,
  // raw bank contents at each read address
  output logic [`RF_NR_READ-1:0][`RF_DATA_W-1:0]     rdata_o
);

  // storage array
  // maps to LUT RAM with one write port and several read ports
  logic [`RF_DATA_W-1:0] mem_q [`RF_NUM_REGS];

  // synchronous write at the rising edge
  // register zero is written like any other, the zero rule is applied on the output mux
  always_ff @(posedge clk_i) begin
    if (wr_i.we) begin
      mem_q[wr_i.addr] <= wr_i.data;
    end
  end

  // asynchronous reads
  // a read in the write cycle still sees the old word
  for (genvar k = 0; k < `RF_NR_READ; k++) begin : g_read
    assign rdata_o[k] = mem_q[raddr_i[k]];
  end

  // this bank only knows its own writes
  // whether the word is the current one is decided by the live value table
  // the surrounding register file picks between banks

  // note on mapping
  // every read port replicates the LUT RAM in the fabric
  // so the read port count drives area linearly

  // note on contents
  // there is no reset and no initial value
  // software must write a register before reading it

  // note on timing
  // address to data is a pure LUT path
  // the bank select mux adds one more level after it

endmodule

// File: regfile_tb.sv
// self-checking testbench that drives the register file top level and runs as the simulation top
`timescale 1ns/1ps
`include "regfile_macros.svh"

module regfile_tb;

  // clock period in ns
  localparam int CLK_PERIOD = 8;
  // length of the random phase in cycles
  localparam int RAND_CYCLES = 2000;
  // a write is readable from the cycle after its edge
  localparam int VISIBLE_LIMIT = 1;

  logic clk_i;
  logic rst_ni;
  regfile_pkg::wr_port_t [`RF_NR_WRITE-1:0] wr;
  logic [`RF_NR_READ-1:0][`RF_ADDR_W-1:0] raddr;
  logic [`RF_NR_READ-1:0][`RF_DATA_W-1:0] rdata;

  // shadow copy of the architectural registers
  logic [`RF_DATA_W-1:0] shadow [`RF_NUM_REGS];

  // compare process runs only once the DUT is out of reset
  bit check_en;
  int check_count;
  integer seed;

  // stimulus scratch
  logic [31:0] rnd_ctl;
  logic [`RF_DATA_W-1:0] word0;
  logic [`RF_DATA_W-1:0] word1;
  logic [`RF_DATA_W-1:0] old_word;

  regfile_top dut (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr_i    (wr),
    .raddr_i (raddr),
    .rdata_o (rdata)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  // expected read data from the shadow copy
  // x0 is hardwired to zero
  function automatic logic [`RF_DATA_W-1:0] expected_rdata(input logic [`RF_ADDR_W-1:0] addr);
    logic [`RF_DATA_W-1:0] value;
    if (addr == '0) begin
      value = '0;
    end else begin
      value = shadow[addr];
    end
    return value;
  endfunction

  // builds one commit port request
  function automatic regfile_pkg::wr_port_t write_req(input logic we,
                                                      input logic [`RF_ADDR_W-1:0] addr,
                                                      input logic [`RF_DATA_W-1:0] data);
    regfile_pkg::wr_port_t req;
    req.we   = we;
    req.addr = addr;
    req.data = data;
    return req;
  endfunction

  task automatic check_read(input int port, input logic [`RF_DATA_W-1:0] exp);
    check_count++;
    assert (rdata[port] === exp) else begin
      $display("FAIL time=%0t signal=rdata_o[%0d] expected=%08h got=%08h",
               $time, port, exp, rdata[port]);
      $display("TEST FAILED");
      $fatal(1, "read data mismatch");
    end
  endtask

  // all inputs change on the falling edge only
  task automatic drive(input regfile_pkg::wr_port_t w0, input regfile_pkg::wr_port_t w1,
                       input logic [`RF_ADDR_W-1:0] a0, input logic [`RF_ADDR_W-1:0] a1);
    @(negedge clk_i);
    wr[0]    = w0;
    wr[1]    = w1;
    raddr[0] = a0;
    raddr[1] = a1;
  endtask

  // idles the commit ports until a read port shows the value
  task automatic wait_for_value(input int port, input logic [`RF_DATA_W-1:0] value,
                                input int limit);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && (cycles < limit)) begin
      @(negedge clk_i);
      wr = '0;
      #3;
      seen = (rdata[port] === value);
      cycles++;
    end
    if (!seen) begin
      $display("timeout: read port %0d did not return %08h within %0d cycles",
               port, value, limit);
      $display("TEST FAILED");
      $fatal(1, "wait for read data timed out");
    end
  endtask

  // model update in port order so port 1 overrides port 0
  always @(posedge clk_i) begin
    if (rst_ni) begin
      for (int j = 0; j < `RF_NR_WRITE; j++) begin
        if (wr[j].we) begin
          shadow[wr[j].addr] = wr[j].data;
        end
      end
    end
  end

  // compare process samples mid low phase after the drive has settled
  always @(negedge clk_i) begin
    #2;
    if (check_en) begin
      for (int k = 0; k < `RF_NR_READ; k++) begin
        check_read(k, expected_rdata(raddr[k]));
      end
    end
  end

  initial begin
    seed      = 97;
    check_count = 0;
    check_en  = 1'b0;
    rst_ni    = 1'b0;
    wr        = '0;
    raddr     = '0;
    for (int i = 0; i < `RF_NUM_REGS; i++) begin
      shadow[i] = '0;
    end

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni   = 1'b1;
    check_en = 1'b1;

    // fill every register through port 0 with reads parked on x0
    for (int r = 0; r < `RF_NUM_REGS; r++) begin
      word0 = $random(seed);
      drive(write_req(1'b1, `RF_ADDR_W'(r), word0), '0, '0, '0);
    end
    // sweep both read ports over the whole file
    for (int r = 0; r < `RF_NUM_REGS; r++) begin
      drive('0, '0, `RF_ADDR_W'(r), `RF_ADDR_W'(`RF_NUM_REGS - 1 - r));
    end

    // odd registers through port 1 only so the table moves them to bank 1
    for (int r = 1; r < `RF_NUM_REGS; r += 2) begin
      word1 = $random(seed);
      drive('0, write_req(1'b1, `RF_ADDR_W'(r), word1), `RF_ADDR_W'(r), `RF_ADDR_W'(r));
      wait_for_value(0, word1, VISIBLE_LIMIT);
    end

    // same register from both ports in one cycle
    word0 = $random(seed);
    word1 = ~word0;
    drive(write_req(1'b1, 5'd7, word0), write_req(1'b1, 5'd7, word1), 5'd7, 5'd7);
    wait_for_value(1, word1, VISIBLE_LIMIT);
    drive('0, '0, 5'd7, 5'd7);
    #3;
    check_read(0, word1);
    check_read(1, word1);

    // read in the write cycle sees the old word
    // one cycle later it sees the new one
    old_word = expected_rdata(5'd12);
    word0    = ~old_word;
    drive(write_req(1'b1, 5'd12, word0), '0, 5'd12, 5'd12);
    #3;
    check_read(0, old_word);
    check_read(1, old_word);
    drive('0, '0, 5'd12, 5'd12);
    #3;
    check_read(0, word0);
    check_read(1, word0);

    // random traffic on both sides with x0 included
    for (int n = 0; n < RAND_CYCLES; n++) begin
      rnd_ctl = $random(seed);
      word0   = $random(seed);
      word1   = $random(seed);
      drive(write_req(rnd_ctl[20], rnd_ctl[4:0], word0),
            write_req(rnd_ctl[21], rnd_ctl[9:5], word1),
            rnd_ctl[14:10], rnd_ctl[19:15]);
    end

    // let the last writes land and get compared
    drive('0, '0, '0, '0);
    drive('0, '0, '0, '0);
    @(negedge clk_i);
    #3;
    $display("read checks done: %0d", check_count);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: regfile_top.sv
// register file boundary facing the commit and issue stages of the core
`timescale 1ns/1ps
`include "regfile_macros.svh"

module regfile_top (
  // core clock
  input  logic                                        clk_i,
  // asynchronous active-low reset, clears the live value table
  input  logic                                        rst_ni,
  // commit side
  // port 1 wins when both ports hit one register in one cycle
  input  regfile_pkg::wr_port_t [`RF_NR_WRITE-1:0]    wr_i,
  // issue side
  // reads are combinational, zero cycles from address to data
  input  logic [`RF_NR_READ-1:0][`RF_ADDR_W-1:0]      raddr_i,
  output logic [`RF_NR_READ-1:0][`RF_DATA_W-1:0]      rdata_o
);

  // integer register file, x0 hardwired to zero
  regfile_fpga #(
    .ZERO_REG_ZERO (1'b1)
  ) u_regfile (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr_i    (wr_i),
    .raddr_i (raddr_i),
    .rdata_o (rdata_o)
  );

  // nothing else lives here
  // pipeline registers, if any, belong to the stages around this block

  // visibility rules at this boundary
  // a commit before edge N is readable just after edge N
  // a read in the same cycle as the commit returns the old value
  // the issue stage forwards results itself where it needs them

  // reset rules at this boundary
  // only the bank selects are cleared
  // register contents stay undefined until written

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the register file testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
  -f project.f \
  --top-module regfile_tb \
  -o regfile_sim

# the simulator exit code is not used, the log decides
./obj_dir/regfile_sim 2>&1 | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
